/* logic/display_settings.svh */
// screen geometry and framebuffer sizing macros
`ifndef DISPLAY_SETTINGS_SVH
`define DISPLAY_SETTINGS_SVH

// ----------------------------------------
// screen geometry
// ----------------------------------------
`define DISPLAY_COLS 16
`define DISPLAY_ROWS 8
`define BYTES_PER_PIXEL 2   // byte 0 is the low colour byte

// ----------------------------------------
// framebuffer
// ----------------------------------------
`define FB_BYTES (`DISPLAY_COLS * `DISPLAY_ROWS * `BYTES_PER_PIXEL)
`define FB_ADDR_W 8         // log2 of FB_BYTES

`endif

/* logic/display_pkg.sv */
// display types: screen addresses, colour, opcodes
// and the command word with its fill and pixel views
`include "display_settings.svh"

package display_pkg;

    // ----------------------------------------
    // addresses and colour
    // ----------------------------------------
    typedef logic [$clog2(`DISPLAY_COLS + 1)-1:0] col_addr_t;   // room for x1+width
    typedef logic [$clog2(`DISPLAY_ROWS + 1)-1:0] row_addr_t;   // room for y1+height
    typedef logic [$clog2(`BYTES_PER_PIXEL)-1:0]  pixel_addr_t; // byte within a pixel
    typedef logic [`BYTES_PER_PIXEL*8-1:0]        color_t;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_FILL  = 2'd1,
        OP_PIXEL = 2'd2
    } opcode_t;

    // ----------------------------------------
    // command word, opcode on top in both views
    // ----------------------------------------
    typedef struct packed {
        opcode_t   opcode;
        col_addr_t x1;
        row_addr_t y1;
        col_addr_t width;
        row_addr_t height;
        color_t    color;
    } fill_cmd_t;

    typedef struct packed {
        opcode_t   opcode;
        col_addr_t x;
        row_addr_t y;
        logic [$bits(col_addr_t)+$bits(row_addr_t)-1:0] unused; // where width/height sit
        color_t    color;
    } pixel_cmd_t;

    typedef union packed {
        fill_cmd_t  fill;
        pixel_cmd_t pixel;
    } cmd_word_t;

endpackage

/* logic/cmd_intake.sv */
// command intake with the four-phase host handshake, command decode
// and the one-deep pending slot feeding the walker
`timescale 1ns/1ps

module cmd_intake import display_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      cmd_req,
    input  cmd_word_t cmd_word,
    input  logic      area_ready,
    output logic      cmd_ack,
    output logic      area_valid,
    output col_addr_t x1,
    output row_addr_t y1,
    output col_addr_t width,
    output row_addr_t height,
    output color_t    color,
    output logic      pending
);
    // decoded area from the incoming word
    col_addr_t dec_x;
    row_addr_t dec_y;
    col_addr_t dec_w;
    row_addr_t dec_h;
    color_t    dec_color;
    logic      is_draw;
    logic      dec_keep;
    logic      accept;
    logic      take;

    // ----------------------------------------
    // decode by opcode into one area
    // ----------------------------------------
    always_comb begin
        dec_x     = cmd_word.fill.x1;       // position and colour share bits in both views
        dec_y     = cmd_word.fill.y1;
        dec_w     = cmd_word.fill.width;
        dec_h     = cmd_word.fill.height;
        dec_color = cmd_word.fill.color;
        is_draw   = 1'b0;
        case (cmd_word.fill.opcode)
            OP_FILL: is_draw = 1'b1;
            OP_PIXEL: begin
                dec_w   = col_addr_t'(1);       // single pixel area
                dec_h   = row_addr_t'(1);
                is_draw = 1'b1;
            end
            default: is_draw = 1'b0;            // nop and unused code
        endcase
    end

    assign dec_keep   = is_draw && (dec_w != '0) && (dec_h != '0);
    assign accept     = cmd_req && !cmd_ack && !pending;
    assign take       = pending && area_ready;
    assign area_valid = pending;

    // ----------------------------------------
    // handshake and slot state
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cmd_ack <= 1'b0;
            pending <= 1'b0;
        end else begin
            if (take)
                pending <= 1'b0;
            if (accept) begin
                cmd_ack <= 1'b1;
                pending <= dec_keep;            // dropped words still get their ack
            end else if (!cmd_req) begin
                cmd_ack <= 1'b0;
            end
        end
    end

    // slot contents
    always_ff @(posedge clk) begin
        if (accept) begin
            x1     <= dec_x;
            y1     <= dec_y;
            width  <= dec_w;
            height <= dec_h;
            color  <= dec_color;
        end
    end

endmodule

/* logic/fill_area_walker.sv */
// fill area walker: steps rows, columns and bytes of an area
// from the far corner down to the origin, one byte per cycle
`timescale 1ns/1ps
`include "display_settings.svh"

module fill_area_walker import display_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        area_valid,
    input  col_addr_t   x1,
    input  row_addr_t   y1,
    input  col_addr_t   width,
    input  row_addr_t   height,
    input  color_t      color,
    output logic        area_ready,
    output logic        wr_valid,
    output row_addr_t   row,
    output col_addr_t   column,
    output pixel_addr_t pixel,
    output logic [7:0]  data
);
    localparam pixel_addr_t TOP_BYTE = pixel_addr_t'(`BYTES_PER_PIXEL - 1);

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } walk_state_t;

    walk_state_t state;

    // far corner of the incoming area, inclusive
    col_addr_t x_far;
    row_addr_t y_far;

    // area held while running
    col_addr_t x_lo;
    col_addr_t x_hi;
    row_addr_t y_lo;
    color_t    color_q;

    logic        load;
    logic        last;
    row_addr_t   row_nxt;
    col_addr_t   column_nxt;
    pixel_addr_t pixel_nxt;

    function automatic logic [7:0] color_byte(input color_t c, input pixel_addr_t idx);
        return c[int'(idx)*8 +: 8];
    endfunction

    assign x_far      = x1 + width - col_addr_t'(1);
    assign y_far      = y1 + height - row_addr_t'(1);
    assign area_ready = (state == ST_IDLE);
    assign load       = area_valid && area_ready;
    assign last       = (row == y_lo) && (column == x_lo) && (pixel == '0);

    // ----------------------------------------
    // next position, byte then column then row
    // ----------------------------------------
    always_comb begin
        row_nxt    = row;
        column_nxt = column;
        pixel_nxt  = pixel - pixel_addr_t'(1);
        if (pixel == '0) begin
            pixel_nxt = TOP_BYTE;
            if (column == x_lo) begin
                column_nxt = x_hi;              // wrap to right edge
                row_nxt    = row - row_addr_t'(1);
            end else begin
                column_nxt = column - col_addr_t'(1);
            end
        end
    end

    // ----------------------------------------
    // walk control
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= ST_IDLE;
            wr_valid <= 1'b0;
            row      <= '0;
            column   <= '0;
            pixel    <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load) begin
                        state    <= ST_RUN;
                        wr_valid <= 1'b1;       // first byte goes out next cycle
                        row      <= y_far;
                        column   <= x_far;
                        pixel    <= TOP_BYTE;
                    end
                end
                ST_RUN: begin
                    if (last) begin
                        state    <= ST_IDLE;
                        wr_valid <= 1'b0;
                    end else begin
                        row    <= row_nxt;
                        column <= column_nxt;
                        pixel  <= pixel_nxt;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // area latch and outgoing byte
    always_ff @(posedge clk) begin
        if (load) begin
            x_lo    <= x1;
            x_hi    <= x_far;
            y_lo    <= y1;
            color_q <= color;
            data    <= color_byte(color, TOP_BYTE);
        end else if (state == ST_RUN) begin
            data <= color_byte(color_q, pixel_nxt);
        end
    end

endmodule

/* logic/framebuffer_writer.sv */
// framebuffer writer: row/column/byte to linear byte address,
// registered write strobe, address and data toward the RAM
`timescale 1ns/1ps
`include "display_settings.svh"

module framebuffer_writer import display_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  wr_valid,
    input  row_addr_t             row,
    input  col_addr_t             column,
    input  pixel_addr_t           pixel,
    input  logic [7:0]            data,
    output logic                  ram_we,
    output logic [`FB_ADDR_W-1:0] ram_waddr,
    output logic [7:0]            ram_wdata,
    output logic                  write_busy
);
    logic [`FB_ADDR_W-1:0] pixel_index;     // row-major pixel number
    logic [`FB_ADDR_W-1:0] byte_addr;

    // ----------------------------------------
    // address arithmetic
    // ----------------------------------------
    assign pixel_index = (`FB_ADDR_W)'(row * `DISPLAY_COLS + column);
    assign byte_addr   = (`FB_ADDR_W)'(pixel_index * `BYTES_PER_PIXEL + pixel);

    // ----------------------------------------
    // write register stage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ram_we <= 1'b0;
        end else begin
            ram_we <= wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            ram_waddr <= byte_addr;
            ram_wdata <= data;
        end
    end

    // byte presented or still registered ahead of the RAM
    assign write_busy = wr_valid | ram_we;

endmodule

/* logic/framebuffer_ram.sv */
// framebuffer RAM: one write port, one registered read port
`timescale 1ns/1ps
`include "display_settings.svh"

module framebuffer_ram (
    input  logic                  clk,
    input  logic                  we,
    input  logic [`FB_ADDR_W-1:0] waddr,
    input  logic [7:0]            wdata,
    input  logic [`FB_ADDR_W-1:0] raddr,
    output logic [7:0]            rdata
);
    logic [7:0] mem [`FB_BYTES];

    // ----------------------------------------
    // write port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // ----------------------------------------
    // read port, data one cycle after address
    // ----------------------------------------
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];            // old data on same-address write
    end

endmodule

/* logic/display_cmd.sv */
// display command engine top: intake, area walker,
// framebuffer writer and framebuffer RAM
`timescale 1ns/1ps
`include "display_settings.svh"

module display_cmd import display_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmd_req,
    input  cmd_word_t             cmd_word,
    input  logic [`FB_ADDR_W-1:0] rd_addr,
    output logic                  cmd_ack,
    output logic                  busy,
    output logic [7:0]            rd_data
);
    // intake to walker
    logic      area_valid;
    logic      area_ready;
    col_addr_t x1;
    row_addr_t y1;
    col_addr_t width;
    row_addr_t height;
    color_t    color;
    logic      pending;

    // walker to writer
    logic        wr_valid;
    row_addr_t   row;
    col_addr_t   column;
    pixel_addr_t pixel;
    logic [7:0]  data;

    // writer to RAM
    logic                  ram_we;
    logic [`FB_ADDR_W-1:0] ram_waddr;
    logic [7:0]            ram_wdata;
    logic                  write_busy;

    cmd_intake u_intake (
        .clk        (clk),
        .reset      (reset),
        .cmd_req    (cmd_req),
        .cmd_word   (cmd_word),
        .area_ready (area_ready),
        .cmd_ack    (cmd_ack),
        .area_valid (area_valid),
        .x1         (x1),
        .y1         (y1),
        .width      (width),
        .height     (height),
        .color      (color),
        .pending    (pending)
    );

    fill_area_walker u_walker (
        .clk        (clk),
        .reset      (reset),
        .area_valid (area_valid),
        .x1         (x1),
        .y1         (y1),
        .width      (width),
        .height     (height),
        .color      (color),
        .area_ready (area_ready),
        .wr_valid   (wr_valid),
        .row        (row),
        .column     (column),
        .pixel      (pixel),
        .data       (data)
    );

    framebuffer_writer u_writer (
        .clk        (clk),
        .reset      (reset),
        .wr_valid   (wr_valid),
        .row        (row),
        .column     (column),
        .pixel      (pixel),
        .data       (data),
        .ram_we     (ram_we),
        .ram_waddr  (ram_waddr),
        .ram_wdata  (ram_wdata),
        .write_busy (write_busy)
    );

    framebuffer_ram u_ram (
        .clk   (clk),
        .we    (ram_we),
        .waddr (ram_waddr),
        .wdata (ram_wdata),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

    // any stage still holding work
    assign busy = pending | ~area_ready | write_busy;

endmodule

/* verification/display_cmd_checks.svh */
// compare tasks for colours and status flags,
// framebuffer readback through the top-level read port
`ifndef DISPLAY_CMD_CHECKS_SVH
`define DISPLAY_CMD_CHECKS_SVH

task automatic check_color(input string name, input color_t expected, input color_t actual);
    if (actual !== expected)
        fail_now($sformatf("mismatch %s: expected %h, actual %h", name, expected, actual));
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected)
        fail_now($sformatf("mismatch %s: expected %b, actual %b", name, expected, actual));
endtask

// ----------------------------------------
// readback, one byte per cycle
// ----------------------------------------
task automatic read_framebuffer(input string name);
    logic [7:0] got [`FB_BYTES];
    color_t     actual;
    color_t     expected;
    int         a;
    int         p;
    int         b;
    int         base;
    for (a = 0; a <= `FB_BYTES; a++) begin
        @(posedge clk);
        if (a < `FB_BYTES)
            rd_addr <= (`FB_ADDR_W)'(a);
        @(negedge clk);
        if (a > 0)
            got[a-1] = rd_data;         // data for the previous address
    end
    for (p = 0; p < `DISPLAY_COLS * `DISPLAY_ROWS; p++) begin
        base = p * `BYTES_PER_PIXEL;
        for (b = 0; b < `BYTES_PER_PIXEL; b++) begin
            actual[b*8 +: 8]   = got[base + b];
            expected[b*8 +: 8] = shadow[base + b];
        end
        check_color($sformatf("%s row %0d col %0d", name, p / `DISPLAY_COLS,
                              p % `DISPLAY_COLS), expected, actual);
    end
endtask

`endif

/* verification/display_cmd_tb.sv */
// display command engine testbench with host driver,
// stimulus table, shadow framebuffer, LCG and watchdog
`timescale 1ns/1ps
`include "display_settings.svh"

module display_cmd_tb import display_pkg::*; ();
    localparam int CLK_PERIOD = 8;

    typedef struct packed {
        int     x;
        int     y;
        int     w;
        int     h;
        color_t color;
    } area_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  cmd_req;
    cmd_word_t             cmd_word;
    logic [`FB_ADDR_W-1:0] rd_addr;
    logic                  cmd_ack;
    logic                  busy;
    logic [7:0]            rd_data;

    logic [7:0]  shadow [`FB_BYTES];    // expected framebuffer bytes
    int unsigned lcg_state = 90;
    longint      limit_ns = 0;

    // stimulus table with one entry per command
    string     step_name[$];
    cmd_word_t step_word[$];
    area_t     step_area[$];
    bit        step_wait[$];
    bit        step_stall[$];

    display_cmd u_dut (
        .clk      (clk),
        .reset    (reset),
        .cmd_req  (cmd_req),
        .cmd_word (cmd_word),
        .rd_addr  (rd_addr),
        .cmd_ack  (cmd_ack),
        .busy     (busy),
        .rd_data  (rd_data)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    `include "display_cmd_checks.svh"

    function automatic int rand_below(input int unsigned n);
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return int'((lcg_state >> 16) % n);
    endfunction

    // painted bytes follow the address and byte order rules
    function automatic void paint_shadow(input area_t a);
        int r;
        int c;
        int b;
        for (r = a.y; r < a.y + a.h; r++)
            for (c = a.x; c < a.x + a.w; c++)
                for (b = 0; b < `BYTES_PER_PIXEL; b++)
                    shadow[(r * `DISPLAY_COLS + c) * `BYTES_PER_PIXEL + b] = a.color[b*8 +: 8];
    endfunction

    task automatic add_step(input string name, input opcode_t op, input int x, input int y,
                            input int w, input int h, input color_t c,
                            input bit wait_idle, input bit stall);
        cmd_word_t cw;
        area_t     a;
        a = '{x: x, y: y, w: w, h: h, color: c};
        if (op == OP_PIXEL) begin
            cw.pixel.opcode = op;
            cw.pixel.x      = col_addr_t'(x);
            cw.pixel.y      = row_addr_t'(y);
            cw.pixel.unused = '0;
            cw.pixel.color  = c;
            a.w = 1;
            a.h = 1;
        end else begin
            cw.fill.opcode = op;
            cw.fill.x1     = col_addr_t'(x);
            cw.fill.y1     = row_addr_t'(y);
            cw.fill.width  = col_addr_t'(w);
            cw.fill.height = row_addr_t'(h);
            cw.fill.color  = c;
            if (op == OP_NOP)
                a.w = 0;                // nothing painted
        end
        step_name.push_back(name);
        step_word.push_back(cw);
        step_area.push_back(a);
        step_wait.push_back(wait_idle);
        step_stall.push_back(stall);
    endtask

    // ----------------------------------------
    // four-phase host handshake
    // ----------------------------------------
    task automatic send_cmd(input cmd_word_t w, output int ack_wait);
        @(posedge clk);
        cmd_word <= w;
        cmd_req  <= 1'b1;
        ack_wait = 0;
        @(negedge clk);
        while (!cmd_ack) begin
            ack_wait++;
            @(negedge clk);
        end
        @(posedge clk);
        cmd_req <= 1'b0;
        @(negedge clk);
        while (cmd_ack)
            @(negedge clk);
    endtask

    task automatic build_table();
        int i;
        int x;
        int y;
        int w;
        int h;
        add_step("full_clear", OP_FILL, 0, 0, 16, 8, 16'hA55A, 1, 0);
        add_step("rect_fill", OP_FILL, 3, 2, 5, 4, 16'h3C81, 1, 0);
        add_step("set_pixel", OP_PIXEL, 10, 6, 0, 0, 16'hBEEF, 1, 0);
        add_step("zero_width", OP_FILL, 2, 2, 0, 3, 16'hFFFF, 0, 0);
        add_step("zero_height", OP_FILL, 4, 1, 6, 0, 16'hFFFF, 0, 0);
        add_step("nop", OP_NOP, 1, 1, 4, 4, 16'h0000, 1, 0);
        // third one finds the slot full while the walker runs
        add_step("b2b_big", OP_FILL, 0, 0, 16, 8, 16'h0F0F, 0, 0);
        add_step("b2b_mid", OP_FILL, 2, 1, 10, 5, 16'h7711, 0, 0);
        add_step("b2b_top", OP_FILL, 6, 3, 4, 3, 16'hC3E0, 1, 1);
        for (i = 0; i < 10; i++) begin
            w = 1 + rand_below(`DISPLAY_COLS);
            h = 1 + rand_below(`DISPLAY_ROWS);
            x = rand_below(`DISPLAY_COLS - w + 1);
            y = rand_below(`DISPLAY_ROWS - h + 1);
            add_step($sformatf("random_%0d", i), OP_FILL, x, y, w, h,
                     color_t'(rand_below(65536)), 1, 0);
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int     ack_wait;
        int     i;
        longint budget;
        reset    <= 1'b1;
        cmd_req  <= 1'b0;
        cmd_word <= '0;
        rd_addr  <= '0;
        build_table();
        budget = 10;                    // reset and start-up cycles
        for (i = 0; i < step_name.size(); i++) begin
            budget += step_area[i].w * step_area[i].h * `BYTES_PER_PIXEL + 20;
            if (step_wait[i])
                budget += `FB_BYTES + 4; // readback sweep
        end
        limit_ns = budget * CLK_PERIOD;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_flag("reset cmd_ack", 1'b0, cmd_ack);
        check_flag("reset busy", 1'b0, busy);
        for (i = 0; i < step_name.size(); i++) begin
            paint_shadow(step_area[i]);
            send_cmd(step_word[i], ack_wait);
            check_flag({step_name[i], " ack stall"}, step_stall[i], ack_wait > 1);
            // a drawing command keeps the engine busy past its handshake
            check_flag({step_name[i], " busy"}, step_area[i].w * step_area[i].h != 0, busy);
            if (step_wait[i]) begin
                while (busy)
                    @(negedge clk);
                read_framebuffer(step_name[i]);
            end
        end
        $display("test passed");
        $finish;
    end

    // watchdog armed once the table sets its budget
    initial begin
        wait (limit_ns != 0);
        #(limit_ns);
        fail_now("timeout: commands did not finish within the expected time");
    end

endmodule

/* display_cmd.f */
+incdir+logic
+incdir+verification
logic/display_pkg.sv
logic/cmd_intake.sv
logic/fill_area_walker.sv
logic/framebuffer_writer.sv
logic/framebuffer_ram.sv
logic/display_cmd.sv
verification/display_cmd_tb.sv

/* Makefile */
# Verilator build and run for the display command engine testbench

VERILATOR  ?= verilator
TOP        ?= display_cmd_tb
FILELIST   ?= display_cmd.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --timescale 1ns/1ps -j 0
SEED_FLAGS ?=
SIM        := $(BUILD_DIR)/V$(TOP)
SOURCES    := $(wildcard logic/*.sv logic/*.svh verification/*.sv verification/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# exit status of the simulator is the pass or fail result
run: $(SIM)
	$(SIM) $(SEED_FLAGS)

clean:
	rm -rf $(BUILD_DIR)
